// File: all.f
src/wb_pkg.sv
src/ramtest_pkg.sv
src/req_timer.sv
src/adgen.sv
src/test_fsm.sv
src/inst_master.sv
src/data_master.sv
src/dp_ram.sv
src/ramtest_top.sv
tests/tb_ramtest.sv

// File: run.sh
#!/usr/bin/env bash
# builds the RAM test with Verilator and runs the regression
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module tb_ramtest \
  -f all.f

# keep the simulation transcript for the pass check
./obj_dir/Vtb_ramtest | tee sim.log

if grep -q "^Regression passed$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: src/adgen.sv
//**********************************************************
// pseudo-random address and data generator
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

module adgen import wb_pkg::*, ramtest_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clear,
  input  logic                    next,
  output logic [wb_addr_bits-1:0] addr,
  output logic [wb_data_bits-1:0] data
);

  logic [wb_addr_bits-1:0] addr_lfsr;
  logic [31:0]             data_hi;
  logic [31:0]             data_lo;

  // one right-shift Galois step of a data half
  function automatic logic [31:0] step_data(input logic [31:0] value);
    logic [31:0] shifted;
    shifted = value >> 1;
    if (value[0]) begin
      shifted = shifted ^ data_taps;
    end
    return shifted;
  endfunction

  // all generators start from the same seeds and so replay one sequence
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      addr_lfsr <= addr_seed;
      data_hi   <= data_seed_hi;
      data_lo   <= data_seed_lo;
    end else if (next) begin
      if (addr_lfsr[0]) begin
        addr_lfsr <= (addr_lfsr >> 1) ^ addr_taps;
      end else begin
        addr_lfsr <= addr_lfsr >> 1;
      end
      data_hi <= step_data(data_hi);
      data_lo <= step_data(data_lo);
    end
  end

  assign addr = addr_lfsr;
  assign data = {data_hi, data_lo};

endmodule

`default_nettype wire

// File: src/data_master.sv
//**********************************************************
// data port master, three writes then one read
// cycle counter, end of test and read compare
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

module data_master import wb_pkg::*, ramtest_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clear,
  input  logic                    slot,
  output wb_req_t                 req,
  input  wb_rsp_t                 rsp,
  output logic                    busy,
  output logic                    last,
  output logic                    err,
  output logic [wb_addr_bits-1:0] fail_addr
);

  localparam int cnt_bits = $clog2(data_cycles);

  logic                    cyc;
  logic                    we;
  logic [cnt_bits-1:0]     cycle_cnt;
  logic                    done;
  logic                    wr_next;
  logic                    rd_next;
  logic [wb_addr_bits-1:0] wr_addr;
  logic [wb_data_bits-1:0] wr_data;
  logic [wb_addr_bits-1:0] rd_addr;
  logic [wb_data_bits-1:0] rd_data;

  assign done    = cyc & rsp.ack;
  assign wr_next = done & we;
  assign rd_next = done & ~we;

  adgen u_writer (
    .clk   (clk),
    .rst   (rst),
    .clear (clear),
    .next  (wr_next),
    .addr  (wr_addr),
    .data  (wr_data)
  );

  adgen u_reader (
    .clk   (clk),
    .rst   (rst),
    .clear (clear),
    .next  (rd_next),
    .addr  (rd_addr),
    .data  (rd_data)
  );

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      cyc <= 1'b0;
      we  <= 1'b0;
    end else if (done) begin
      cyc <= 1'b0;
      we  <= 1'b0;
    end else if (slot) begin
      cyc <= 1'b1;
      // every fourth cycle is a read
      we  <= ~&cycle_cnt[1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      cycle_cnt <= '0;
    end else if (done) begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      err       <= 1'b0;
      fail_addr <= '0;
    end else if (rd_next && !err && (rsp.dat_r != rd_data)) begin
      err       <= 1'b1;
      fail_addr <= rd_addr;
    end
  end

  assign last = done & (cycle_cnt == cnt_bits'(data_cycles - 1));

  // write data always comes from the writer, the RAM ignores it on reads
  assign req = '{
    cyc:   cyc,
    stb:   cyc,
    we:    we,
    adr:   we ? wr_addr : rd_addr,
    dat_w: wr_data
  };

  assign busy = cyc;

endmodule

`default_nettype wire

// File: src/dp_ram.sv
//**********************************************************
// dual-port Wishbone RAM with registered acks
// and a read data fault mask at one address
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

module dp_ram import wb_pkg::*, ramtest_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  fault_t  fault,
  input  wb_req_t inst_req,
  output wb_rsp_t inst_rsp,
  input  wb_req_t data_req,
  output wb_rsp_t data_rsp
);

  logic [wb_data_bits-1:0] mem [2**wb_addr_bits];
  wb_req_t                 port_req [2];
  logic [1:0]              access;
  logic [1:0]              ack_q;
  logic [wb_data_bits-1:0] rdata_q [2];

  function automatic logic [wb_data_bits-1:0] fault_bits(
    input fault_t                  f,
    input logic [wb_addr_bits-1:0] adr
  );
    if (f.en && (adr == f.addr)) begin
      return f.mask;
    end
    return '0;
  endfunction

  // port 0 is instruction, port 1 is data
  assign port_req[0] = inst_req;
  assign port_req[1] = data_req;

  // first cycle of a strobe, not the ack cycle
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      access[p] = port_req[p].cyc & port_req[p].stb & ~ack_q[p];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= '0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (access[p]) begin
        if (port_req[p].we) begin
          mem[port_req[p].adr] <= port_req[p].dat_w;
        end
        rdata_q[p] <= mem[port_req[p].adr] ^ fault_bits(fault, port_req[p].adr);
      end
    end
  end

  assign inst_rsp = '{ack: ack_q[0], dat_r: rdata_q[0]};
  assign data_rsp = '{ack: ack_q[1], dat_r: rdata_q[1]};

endmodule

`default_nettype wire

// File: src/inst_master.sv
//**********************************************************
// instruction port read master with data compare
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

module inst_master import wb_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clear,
  input  logic                    slot,
  output wb_req_t                 req,
  input  wb_rsp_t                 rsp,
  output logic                    busy,
  output logic                    err,
  output logic [wb_addr_bits-1:0] fail_addr
);

  logic                    cyc;
  logic                    done;
  logic [wb_addr_bits-1:0] gen_addr;
  logic [wb_data_bits-1:0] gen_data;

  // ack of our own cycle, also steps the generator
  assign done = cyc & rsp.ack;

  adgen u_adgen (
    .clk   (clk),
    .rst   (rst),
    .clear (clear),
    .next  (done),
    .addr  (gen_addr),
    .data  (gen_data)
  );

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      cyc <= 1'b0;
    end else if (done) begin
      cyc <= 1'b0;
    end else if (slot) begin
      cyc <= 1'b1;
    end
  end

  // keep only the first mismatch
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      err       <= 1'b0;
      fail_addr <= '0;
    end else if (done && !err && (rsp.dat_r != gen_data)) begin
      err       <= 1'b1;
      fail_addr <= gen_addr;
    end
  end

  // read only, address stays put until the generator steps on ack
  assign req = '{cyc: cyc, stb: cyc, we: 1'b0, adr: gen_addr, dat_w: '0};

  assign busy = cyc;

endmodule

`default_nettype wire

// File: src/ramtest_pkg.sv
//**********************************************************
// RAM test timing, LFSR seeds and taps, test length
// run state enum, status and fault structs
//**********************************************************
`default_nettype none

package ramtest_pkg;
  import wb_pkg::*;

  // request spacing per port, in bus clock cycles
  localparam int inst_period = 31;
  localparam int inst_phase  = 19;
  localparam int data_period = 17;
  localparam int data_phase  = 7;

  // data bus cycles per test, 3/4 writes and 1/4 reads
  localparam int data_cycles = 1024;

  // maximal 12-bit Galois LFSR, x^12 + x^6 + x^4 + x + 1
  localparam logic [wb_addr_bits-1:0] addr_seed = 12'h7db;
  localparam logic [wb_addr_bits-1:0] addr_taps = 12'h829;

  // both data halves share the same 32-bit polynomial
  localparam logic [31:0] data_seed_hi = 32'h7f4d514f;
  localparam logic [31:0] data_seed_lo = 32'h75377599;
  localparam logic [31:0] data_taps    = 32'hd0000001;

  typedef enum logic [1:0] {
    run_idle,
    run_busy,
    run_drain,
    run_done
  } run_state_t;

  // fail_addr is only meaningful with fail_valid set
  typedef struct packed {
    logic                    ended;
    logic                    inst_error;
    logic                    data_error;
    logic                    fail_valid;
    logic [wb_addr_bits-1:0] fail_addr;
  } test_status_t;

  // mask is XORed into read data at addr while en is high
  typedef struct packed {
    logic                    en;
    logic [wb_addr_bits-1:0] addr;
    logic [wb_data_bits-1:0] mask;
  } fault_t;

endpackage

`default_nettype wire

// File: src/ramtest_top.sv
//**********************************************************
// RAM test top with FSM, timers, masters and RAM
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

module ramtest_top import wb_pkg::*, ramtest_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         start,
  input  fault_t       fault,
  output test_status_t status
);

  run_state_t              state;
  logic                    clear;
  logic                    run;
  logic                    last;
  logic                    inst_slot;
  logic                    data_slot;
  logic                    inst_busy;
  logic                    data_busy;
  logic                    inst_err;
  logic                    data_err;
  logic [wb_addr_bits-1:0] inst_fail_addr;
  logic [wb_addr_bits-1:0] data_fail_addr;
  wb_req_t                 inst_req;
  wb_rsp_t                 inst_rsp;
  wb_req_t                 data_req;
  wb_rsp_t                 data_rsp;

  test_fsm u_test_fsm (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .last      (last),
    .inst_busy (inst_busy),
    .clear     (clear),
    .run       (run),
    .state     (state)
  );

  req_timer #(.period(inst_period), .phase(inst_phase)) u_inst_timer (
    .clk   (clk),
    .rst   (rst),
    .clear (clear),
    .run   (run),
    .idle  (~inst_busy),
    .slot  (inst_slot)
  );

  req_timer #(.period(data_period), .phase(data_phase)) u_data_timer (
    .clk   (clk),
    .rst   (rst),
    .clear (clear),
    .run   (run),
    .idle  (~data_busy),
    .slot  (data_slot)
  );

  inst_master u_inst_master (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .slot      (inst_slot),
    .req       (inst_req),
    .rsp       (inst_rsp),
    .busy      (inst_busy),
    .err       (inst_err),
    .fail_addr (inst_fail_addr)
  );

  data_master u_data_master (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .slot      (data_slot),
    .req       (data_req),
    .rsp       (data_rsp),
    .busy      (data_busy),
    .last      (last),
    .err       (data_err),
    .fail_addr (data_fail_addr)
  );

  dp_ram u_dp_ram (
    .clk      (clk),
    .rst      (rst),
    .fault    (fault),
    .inst_req (inst_req),
    .inst_rsp (inst_rsp),
    .data_req (data_req),
    .data_rsp (data_rsp)
  );

  // a data port failure takes precedence in fail_addr
  assign status = '{
    ended:      (state == run_done),
    inst_error: inst_err,
    data_error: data_err,
    fail_valid: inst_err | data_err,
    fail_addr:  data_err ? data_fail_addr : inst_fail_addr
  };

endmodule

`default_nettype wire

// File: src/req_timer.sv
//**********************************************************
// period/phase request timer for one bus port
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

module req_timer #(
  parameter int period = 16,
  parameter int phase  = 0
) (
  input  logic clk,
  input  logic rst,
  input  logic clear,
  input  logic run,
  input  logic idle,
  output logic slot
);

  localparam int cnt_bits = $clog2(period);

  logic [cnt_bits-1:0] count;
  logic                active;

  // count holds while the master waits for its ack
  assign active = run & idle & ~clear;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      count <= '0;
    end else if (active) begin
      if (count == cnt_bits'(period - 1)) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  assign slot = active & (count == cnt_bits'(phase));

endmodule

`default_nettype wire

// File: src/test_fsm.sv
//**********************************************************
// run control FSM with start, clear, drain and done
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

module test_fsm import ramtest_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       last,
  input  logic       inst_busy,
  output logic       clear,
  output logic       run,
  output run_state_t state
);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= run_idle;
      clear <= 1'b0;
    end else begin
      clear <= 1'b0;
      case (state)
        run_idle, run_done: begin
          // a new run restarts generators, timers and counters
          if (start) begin
            clear <= 1'b1;
            state <= run_busy;
          end
        end
        run_busy: begin
          if (last) begin
            state <= run_drain;
          end
        end
        run_drain: begin
          // let an outstanding instruction read finish
          if (!inst_busy) begin
            state <= run_done;
          end
        end
        default: begin
          state <= run_idle;
        end
      endcase
    end
  end

  // requests may only start in run_busy
  assign run = (state == run_busy);

endmodule

`default_nettype wire

// File: src/wb_pkg.sv
//**********************************************************
// Wishbone classic bus widths for the RAM test
// master request and slave response structs
//**********************************************************
`default_nettype none

package wb_pkg;

  // word address into the 4096-word RAM
  localparam int wb_addr_bits = 12;
  localparam int wb_data_bits = 64;

  // driven by a master, held stable until ack
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [wb_addr_bits-1:0] adr;
    logic [wb_data_bits-1:0] dat_w;
  } wb_req_t;

  // driven by the RAM
  typedef struct packed {
    logic                    ack;
    logic [wb_data_bits-1:0] dat_r;
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: tests/ramtest_trace.txt
# name fault_en position mask ended inst_error data_error fail_valid
# position is the index in the address sequence and the fault sits on that address
no_fault       0 0   0000000000000000 1 0 0 0
early_fault    1 10  0000000000000001 1 1 1 1
clean_restart  0 10  0000000000000001 1 0 0 0
mid_fault      1 400 8000000000000000 1 1 0 1
late_fault     1 900 ffffffffffffffff 1 0 0 0
zero_mask      1 10  0000000000000000 1 0 0 0
wide_fault     1 200 00ff00ff00ff00ff 1 1 1 1
inst_only      1 500 0000000100000000 1 1 0 1
final_clean    0 0   0000000000000000 1 0 0 0

// File: tests/tb_ramtest.sv
//**********************************************************
// testbench for the RAM test generator with trace reader,
// run loop and status and state compare tasks
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_ramtest
  import wb_pkg::*, ramtest_pkg::*;
();

  localparam int    end_timeout = 60000;
  localparam string trace_path  = "tests/ramtest_trace.txt";

  logic         clk;
  logic         rst;
  logic         start;
  fault_t       fault;
  test_status_t status;

  int status_errors;
  int state_errors;
  int other_errors;

  ramtest_top u_ramtest_top (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .fault  (fault),
    .status (status)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // address at position k of the generator sequence, stepped from the seed
  function automatic logic [wb_addr_bits-1:0] lfsr_addr_at(input int position);
    logic [wb_addr_bits-1:0] value;
    value = addr_seed;
    for (int k = 0; k < position; k++) begin
      if (value[0]) begin
        value = (value >> 1) ^ addr_taps;
      end else begin
        value = value >> 1;
      end
    end
    return value;
  endfunction

  // fail_addr only counts when a failure is expected
  // flags print as ended, inst_error, data_error, fail_valid
  task automatic check_status(
    input logic [8*24-1:0] name,
    input test_status_t    exp,
    input test_status_t    act
  );
    logic bad;
    bad = (exp.ended != act.ended) || (exp.inst_error != act.inst_error) ||
          (exp.data_error != act.data_error) || (exp.fail_valid != act.fail_valid) ||
          (exp.fail_valid && (exp.fail_addr != act.fail_addr));
    if (bad) begin
      status_errors++;
      $display("** Error %0s status: expected %b%b%b%b/%h, actual %b%b%b%b/%h",
               name, exp.ended, exp.inst_error, exp.data_error, exp.fail_valid,
               exp.fail_addr, act.ended, act.inst_error, act.data_error,
               act.fail_valid, act.fail_addr);
    end
  endtask

  task automatic check_state(
    input logic [8*24-1:0] name,
    input run_state_t      exp,
    input run_state_t      act
  );
    if (exp != act) begin
      state_errors++;
      $display("** Error %0s state: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  // one full run with the fault set up before start
  task automatic run_test(
    input  logic [8*24-1:0]         name,
    input  logic                    fault_en,
    input  int                      position,
    input  logic [wb_data_bits-1:0] mask,
    input  test_status_t            exp,
    output logic                    timed_out
  );
    int cycles;
    @(negedge clk);
    fault.en   = fault_en;
    fault.addr = lfsr_addr_at(position);
    fault.mask = mask;
    start      = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    cycles = 0;
    // start must leave run_done or run_idle before the wait for ended
    check_state(name, run_busy, u_ramtest_top.state);
    while (!status.ended && cycles < end_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!status.ended) begin
      other_errors++;
      timed_out = 1'b1;
      $display("%0s: the run did not end within %0d cycles", name, end_timeout);
    end else begin
      timed_out = 1'b0;
      $display("%0s: run ended after %0d cycles", name, cycles);
      check_status(name, exp, status);
      check_state(name, run_done, u_ramtest_top.state);
    end
  endtask

  initial begin
    int                      fd;
    int                      fields;
    int                      tests_run;
    int                      position;
    logic                    abort;
    logic [8*160-1:0]        line;
    logic [8*24-1:0]         test_name;
    logic                    fault_en;
    logic [wb_data_bits-1:0] mask;
    logic                    exp_ended;
    logic                    exp_inst;
    logic                    exp_data;
    logic                    exp_valid;
    test_status_t            exp;

    status_errors = 0;
    state_errors  = 0;
    other_errors  = 0;
    tests_run     = 0;
    abort         = 1'b0;
    rst           = 1'b1;
    start         = 1'b0;
    fault         = '0;

    repeat (5) @(negedge clk);
    rst = 1'b0;

    // all status bits low and the FSM idle out of reset
    exp = '0;
    check_status("after_reset", exp, status);
    check_state("after_reset", run_idle, u_ramtest_top.state);

    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      other_errors++;
      abort = 1'b1;
      $display("could not open the trace file %0s", trace_path);
    end

    // comment and blank lines do not parse into all eight fields
    while (!abort && $fgets(line, fd) != 0) begin
      fields = $sscanf(line, "%s %b %d %h %b %b %b %b", test_name, fault_en, position,
                       mask, exp_ended, exp_inst, exp_data, exp_valid);
      if (fields == 8) begin
        exp.ended      = exp_ended;
        exp.inst_error = exp_inst;
        exp.data_error = exp_data;
        exp.fail_valid = exp_valid;
        exp.fail_addr  = exp_valid ? lfsr_addr_at(position) : '0;
        run_test(test_name, fault_en, position, mask, exp, abort);
        tests_run++;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    if (tests_run == 0 && !abort) begin
      other_errors++;
      $display("the trace file held no test lines");
    end

    $display("tests %0d, status errors %0d, state errors %0d, other errors %0d",
             tests_run, status_errors, state_errors, other_errors);
    if (status_errors == 0 && state_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
